/* files.f */
+incdir+.
video_pkg.sv
game_pkg.sv
game_ifs.sv
btn_debounce.sv
vga_timing.sv
char_physics.sv
pixel_gen.sv
platformer_top.sv
tb_platformer.sv

/* Makefile */
# Verilator build and run of the platformer testbench

TOP = tb_platformer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f files.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "Something failed" sim.log; then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

/* tb_platformer.sv */
`timescale 1ns/1ns
`include "game_consts.svh"

module tb_platformer;
    import video_pkg::*;
    import game_pkg::*;

    localparam int LINE_CLKS = (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK) * `PIX_DIV;
    localparam int FRAME_CLKS = LINE_CLKS * (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK);
    localparam int TICK = `GAME_TICK_CYCLES;
    localparam int X_MAX = `H_ACTIVE - `WALL_W - `CHAR_SIZE;
    localparam int Y_REST = `GROUND_Y - `CHAR_SIZE;
    // Debounce plus up to two game ticks before a move shows
    localparam int CHANGE_LIMIT = 2 * TICK + 4 * `DEBOUNCE_CYCLES;
    localparam int SETTLE = 2 * `DEBOUNCE_CYCLES + 4;
    localparam int GAP = 20;

    localparam int KIND_RESET = 0;
    localparam int KIND_HSYNC = 1;
    localparam int KIND_VSYNC = 2;
    localparam int KIND_HOLD = 3;
    localparam int KIND_GLITCH = 4;
    localparam int KIND_JUMP = 5;
    localparam int KIND_PICTURE = 6;
    localparam int KIND_WALK = 7;

    logic sys_clk = 1'b0;
    logic sys_rst_n;
    logic left_btn;
    logic right_btn;
    logic jump_btn;
    logic hsync;
    logic vsync;
    logic [11:0] rgb;
    logic signed [10:0] char_x;
    logic signed [10:0] char_y;
    logic on_ground;

    int err_cnt;
    bit aborted;
    // Expected char_x as walking moves it
    pos_t model_x;

    // Step table with buttons as {jump, right, left}
    string names[$];
    logic [2:0] btn_q[$];
    int hold_q[$];
    int kind_q[$];
    int exp_q[$];

    platformer_top uut (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .left_btn  (left_btn),
        .right_btn (right_btn),
        .jump_btn  (jump_btn),
        .hsync     (hsync),
        .vsync     (vsync),
        .rgb       (rgb),
        .char_x    (char_x),
        .char_y    (char_y),
        .on_ground (on_ground)
    );

    always #5 sys_clk = ~sys_clk;

    task automatic add_step(input string name, input logic [2:0] btns, input int hold,
                            input int kind, input int exp_val);
        names.push_back(name);
        btn_q.push_back(btns);
        hold_q.push_back(hold);
        kind_q.push_back(kind);
        exp_q.push_back(exp_val);
    endtask

    task automatic drive_buttons(input logic [2:0] btns);
        left_btn = btns[0];
        right_btn = btns[1];
        jump_btn = btns[2];
    endtask

    task automatic check_pos(input string name, input pos_t exp_v, input pos_t act);
        if (act !== exp_v) begin
            $display("mismatch %s: expected %0d, actual %0d", name, exp_v, act);
            err_cnt++;
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t exp_v, input rgb_t act);
        if (act !== exp_v) begin
            $display("mismatch %s: expected %h, actual %h", name, exp_v, act);
            err_cnt++;
        end
    endtask

    task automatic check_count(input string name, input int exp_v, input int act);
        if (act != exp_v) begin
            $display("mismatch %s: expected %0d, actual %0d", name, exp_v, act);
            err_cnt++;
        end
    endtask

    task automatic report_timeout(input string name, input string what);
        $display("%s: timed out waiting for %s", name, what);
        err_cnt++;
        aborted = 1'b1;
    endtask

    task automatic pos_changes(input bit on_y, input int limit, output bit ok);
        pos_t start;
        int n;
        start = on_y ? char_y : char_x;
        ok = 1'b0;
        n = 0;
        while (!ok && n < limit) begin
            @(negedge sys_clk);
            n++;
            ok = ((on_y ? char_y : char_x) != start);
        end
    endtask

    task automatic sync_reaches(input bit is_v, input logic val, input int limit,
                                output bit ok, output int n);
        n = 0;
        ok = ((is_v ? vsync : hsync) == val);
        while (!ok && n < limit) begin
            @(negedge sys_clk);
            n++;
            ok = ((is_v ? vsync : hsync) == val);
        end
    endtask

    task automatic ground_reaches(input logic val, input int limit, output bit ok);
        int n;
        n = 0;
        ok = (on_ground == val);
        while (!ok && n < limit) begin
            @(negedge sys_clk);
            n++;
            ok = (on_ground == val);
        end
    endtask

    task automatic apply_reset(input string name, input int exp_val);
        sys_rst_n = 1'b0;
        repeat (8) @(posedge sys_clk);
        @(negedge sys_clk);
        check_rgb(name, rgb_t'(0), rgb);
        check_count(name, 1, int'(hsync));
        check_count(name, 1, int'(vsync));
        sys_rst_n = 1'b1;
        @(negedge sys_clk);
        check_pos(name, pos_t'(exp_val), char_x);
        check_pos(name, pos_t'(Y_REST), char_y);
        check_count(name, 1, int'(on_ground));
        model_x = pos_t'(exp_val);
    endtask

    // Low time and period measured between falling edges
    task automatic measure_sync(input string name, input bit is_v, input int exp_val);
        int n_low;
        int n_high;
        bit ok;
        sync_reaches(is_v, 1'b1, 2 * FRAME_CLKS, ok, n_high);
        if (ok) sync_reaches(is_v, 1'b0, 2 * FRAME_CLKS, ok, n_high);
        if (ok) sync_reaches(is_v, 1'b1, 2 * FRAME_CLKS, ok, n_low);
        if (ok) sync_reaches(is_v, 1'b0, 2 * FRAME_CLKS, ok, n_high);
        if (!ok) begin
            report_timeout(name, is_v ? "the vsync edge" : "the hsync edge");
        end else begin
            check_count(name, exp_val, n_low);
            check_count(name, is_v ? FRAME_CLKS : LINE_CLKS, n_low + n_high);
        end
    endtask

    task automatic hold_buttons(input string name, input logic [2:0] btns, input int hold,
                                input int exp_val);
        pos_t last_x;
        int moves;
        moves = 0;
        @(negedge sys_clk);
        drive_buttons(btns);
        last_x = char_x;
        repeat (hold) begin
            @(negedge sys_clk);
            if (char_x != last_x) moves++;
            last_x = char_x;
        end
        check_count(name, 0, moves);
        check_pos(name, pos_t'(exp_val), char_x);
    endtask

    task automatic inject_glitches(input string name, input int hold, input int exp_val);
        int elapsed;
        int len;
        int which;
        elapsed = 0;
        while (elapsed < hold) begin
            which = int'($urandom % 3);
            len = 1 + int'($urandom % 10);
            @(negedge sys_clk);
            drive_buttons(3'b001 << which);
            repeat (len) @(negedge sys_clk);
            drive_buttons(3'b000);
            repeat (GAP) @(negedge sys_clk);
            elapsed += len + GAP + 1;
        end
        // Long enough for any wrongly accepted press to show up
        repeat (2 * TICK) @(negedge sys_clk);
        check_pos(name, pos_t'(exp_val), char_x);
        check_pos(name, pos_t'(Y_REST), char_y);
        check_count(name, 1, int'(on_ground));
    endtask

    task automatic run_jump(input string name, input logic [2:0] btns, input int hold,
                            input int exp_val);
        int arc[$];
        int y;
        int v;
        int k;
        bit landed;
        bit ok;
        // Expected char_y after each visible change
        y = exp_val;
        v = `JUMP_VEL;
        landed = 1'b0;
        while (!landed && arc.size() < 200) begin
            if (y - v >= exp_val) begin
                arc.push_back(exp_val);
                landed = 1'b1;
            end else begin
                if (v != 0) arc.push_back(y - v);
                y = y - v;
                v = v - `GRAVITY;
            end
        end
        @(negedge sys_clk);
        drive_buttons(btns);
        repeat (hold) @(negedge sys_clk);
        drive_buttons(3'b000);
        ground_reaches(1'b0, CHANGE_LIMIT, ok);
        k = 0;
        while (ok && k < arc.size()) begin
            // Second press while airborne
            if (k == 2) begin
                drive_buttons(btns);
                repeat (hold) @(negedge sys_clk);
                drive_buttons(3'b000);
            end
            pos_changes(1'b1, CHANGE_LIMIT, ok);
            if (ok) begin
                check_pos(name, pos_t'(arc[k]), char_y);
                k++;
            end
        end
        if (!ok) begin
            report_timeout(name, "the jump arc to progress");
        end else begin
            check_count(name, 1, int'(on_ground));
            repeat (3 * TICK) @(negedge sys_clk);
            check_pos(name, pos_t'(exp_val), char_y);
            check_pos(name, pos_t'(`START_X), char_x);
        end
    endtask

    task automatic count_picture(input string name, input int exp_val);
        int char_clks;
        int blank_bad;
        int n;
        bit ok;
        char_clks = 0;
        blank_bad = 0;
        sync_reaches(1'b1, 1'b1, 2 * FRAME_CLKS, ok, n);
        if (ok) sync_reaches(1'b1, 1'b0, 2 * FRAME_CLKS, ok, n);
        if (!ok) begin
            report_timeout(name, "the start of a frame");
        end else begin
            repeat (FRAME_CLKS) begin
                @(negedge sys_clk);
                if (rgb == `COL_CHAR) char_clks++;
                if ((!hsync || !vsync) && rgb != 12'h000) begin
                    if (blank_bad == 0) check_rgb(name, rgb_t'(0), rgb);
                    blank_bad++;
                end
            end
            check_count(name, exp_val, char_clks);
        end
    endtask

    task automatic walk_to_wall(input string name, input logic [2:0] btns, input int hold,
                                input int exp_val);
        pos_t step;
        pos_t last_x;
        int changes;
        int moves;
        bit ok;
        step = btns[1] ? pos_t'(`WALK_STEP) : -pos_t'(`WALK_STEP);
        changes = 0;
        moves = 0;
        ok = 1'b1;
        @(negedge sys_clk);
        drive_buttons(btns);
        while (ok && model_x != pos_t'(exp_val) && changes < `H_ACTIVE) begin
            pos_changes(1'b0, CHANGE_LIMIT, ok);
            if (ok) begin
                model_x = model_x + step;
                check_pos(name, model_x, char_x);
                changes++;
            end
        end
        if (!ok) begin
            report_timeout(name, "char_x to change");
        end else begin
            // Pressed against the wall
            last_x = char_x;
            repeat (hold) begin
                @(negedge sys_clk);
                if (char_x != last_x) moves++;
                last_x = char_x;
            end
            check_count(name, 0, moves);
            check_pos(name, pos_t'(exp_val), char_x);
        end
    endtask

    initial begin
        int fails_before;
        int failed_tests;
        int ran;
        sys_rst_n = 1'b0;
        left_btn = 1'b0;
        right_btn = 1'b0;
        jump_btn = 1'b0;
        err_cnt = 0;
        aborted = 1'b0;
        model_x = pos_t'(`START_X);
        failed_tests = 0;
        ran = 0;
        void'($urandom(4));

        add_step("reset", 3'b000, 0, KIND_RESET, `START_X);
        add_step("hsync", 3'b000, 0, KIND_HSYNC, `H_SYNC * `PIX_DIV);
        add_step("vsync", 3'b000, 0, KIND_VSYNC, `V_SYNC * LINE_CLKS);
        add_step("both_held", 3'b011, 5 * TICK, KIND_HOLD, `START_X);
        add_step("glitches", 3'b000, 5 * TICK, KIND_GLITCH, `START_X);
        add_step("jump_arc", 3'b100, 40, KIND_JUMP, Y_REST);
        add_step("picture", 3'b000, 0, KIND_PICTURE, `CHAR_SIZE * `CHAR_SIZE * `PIX_DIV);
        add_step("walk_right", 3'b010, 10 * TICK, KIND_WALK, X_MAX);
        add_step("walk_left", 3'b001, 10 * TICK, KIND_WALK, `WALL_W);

        for (int i = 0; i < names.size() && !aborted; i++) begin
            fails_before = err_cnt;
            case (kind_q[i])
                KIND_RESET: apply_reset(names[i], exp_q[i]);
                KIND_HSYNC: measure_sync(names[i], 1'b0, exp_q[i]);
                KIND_VSYNC: measure_sync(names[i], 1'b1, exp_q[i]);
                KIND_HOLD: hold_buttons(names[i], btn_q[i], hold_q[i], exp_q[i]);
                KIND_GLITCH: inject_glitches(names[i], hold_q[i], exp_q[i]);
                KIND_JUMP: run_jump(names[i], btn_q[i], hold_q[i], exp_q[i]);
                KIND_PICTURE: count_picture(names[i], exp_q[i]);
                KIND_WALK: walk_to_wall(names[i], btn_q[i], hold_q[i], exp_q[i]);
                default: begin
                    $display("%s: unknown step kind %0d", names[i], kind_q[i]);
                    err_cnt++;
                end
            endcase
            // Release and let the debouncers settle
            @(negedge sys_clk);
            drive_buttons(3'b000);
            repeat (SETTLE) @(negedge sys_clk);
            ran++;
            if (err_cnt == fails_before) begin
                $display("PASS %s", names[i]);
            end else begin
                $display("FAIL %s", names[i]);
                failed_tests++;
            end
        end

        $display("tests run: %0d of %0d, failed: %0d, errors: %0d",
                 ran, names.size(), failed_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end
endmodule

/* platformer_top.sv */
`timescale 1ns/1ns

module platformer_top (
    input  logic sys_clk,
    input  logic sys_rst_n,
    input  logic left_btn,
    input  logic right_btn,
    input  logic jump_btn,
    output logic hsync,
    output logic vsync,
    output logic [11:0] rgb,
    output logic signed [10:0] char_x,
    output logic signed [10:0] char_y,
    output logic on_ground
);
    logic left_lvl;
    logic right_lvl;
    logic jump_pulse;

    vga_if  vga_bus ();
    char_if chr_bus ();

    // Walking uses held levels, jumping uses the press edge
    btn_debounce u_db_left (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .raw       (left_btn),
        .level     (left_lvl),
        .rise      ()
    );

    btn_debounce u_db_right (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .raw       (right_btn),
        .level     (right_lvl),
        .rise      ()
    );

    btn_debounce u_db_jump (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .raw       (jump_btn),
        .level     (),
        .rise      (jump_pulse)
    );

    char_physics u_char (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .left      (left_lvl),
        .right     (right_lvl),
        .jump_rise (jump_pulse),
        .chr       (chr_bus.src)
    );

    vga_timing u_vga (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .vga       (vga_bus.src)
    );

    pixel_gen u_pix (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .vga       (vga_bus.snk),
        .chr       (chr_bus.snk),
        .rgb       (rgb)
    );

    assign hsync = vga_bus.hsync;
    assign vsync = vga_bus.vsync;

    // Status for the testbench
    assign char_x = chr_bus.pos_x;
    assign char_y = chr_bus.pos_y;
    assign on_ground = chr_bus.on_ground;
endmodule

/* pixel_gen.sv */
`timescale 1ns/1ns
`include "game_consts.svh"

module pixel_gen (
    input  logic sys_clk,
    input  logic sys_rst_n,
    vga_if.snk   vga,
    char_if.snk  chr,
    output video_pkg::rgb_t rgb
);
    import video_pkg::*;
    import game_pkg::*;

    pos_t px;
    pos_t py;
    logic in_char;
    logic in_floor;
    logic in_wall;
    rgb_t col_next;

    // Scan position widened to the signed character range
    assign px = pos_t'(vga.x);
    assign py = pos_t'(vga.y);

    assign in_char = (px >= chr.pos_x) && (px < chr.pos_x + pos_t'(`CHAR_SIZE)) &&
                     (py >= chr.pos_y) && (py < chr.pos_y + pos_t'(`CHAR_SIZE));
    assign in_floor = (vga.y >= coord_t'(`GROUND_Y));
    assign in_wall = (vga.x < coord_t'(`WALL_W)) ||
                     (vga.x >= coord_t'(`H_ACTIVE - `WALL_W));

    // Character drawn over everything else
    always_comb begin
        if (in_char) begin
            col_next = rgb_t'(`COL_CHAR);
        end else if (in_floor) begin
            col_next = rgb_t'(`COL_FLOOR);
        end else if (in_wall) begin
            col_next = rgb_t'(`COL_WALL);
        end else begin
            col_next = rgb_t'(`COL_BG);
        end
    end

    // Blank during retrace
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rgb <= '0;
        end else if (vga.pix_tick) begin
            rgb <= vga.video_on ? col_next : '0;
        end
    end
endmodule

/* char_physics.sv */
`timescale 1ns/1ns
`include "game_consts.svh"

module char_physics (
    input logic sys_clk,
    input logic sys_rst_n,
    input logic left,
    input logic right,
    input logic jump_rise,
    char_if.src chr
);
    import game_pkg::*;

    localparam int TICK_W = $clog2(`GAME_TICK_CYCLES);
    localparam pos_t X_MIN = pos_t'(`WALL_W);
    localparam pos_t X_MAX = pos_t'(`H_ACTIVE - `WALL_W - `CHAR_SIZE);
    localparam pos_t Y_REST = pos_t'(`GROUND_Y - `CHAR_SIZE);

    logic [TICK_W-1:0] tick_cnt;
    logic game_tick;
    logic jump_pend;
    logic jump_now;
    pos_t pos_x, pos_y, x_next, y_next, y_try;
    vel_t vel, vel_next;
    logic on_ground, ground_next;
    motion_t state, state_next;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            tick_cnt <= '0;
        end else if (game_tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    assign game_tick = (tick_cnt == TICK_W'(`GAME_TICK_CYCLES - 1));

    // A press between ticks is held for the next tick only
    assign jump_now = jump_pend || jump_rise;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            jump_pend <= 1'b0;
        end else begin
            jump_pend <= game_tick ? 1'b0 : jump_now;
        end
    end

    always_comb begin
        x_next = pos_x;
        y_next = pos_y;
        vel_next = vel;
        ground_next = on_ground;
        y_try = pos_y - pos_t'(vel);

        // Walk only with exactly one direction held
        if (right && !left) begin
            x_next = (pos_x + pos_t'(`WALK_STEP) >= X_MAX) ? X_MAX : pos_x + pos_t'(`WALK_STEP);
        end else if (left && !right) begin
            x_next = (pos_x - pos_t'(`WALK_STEP) <= X_MIN) ? X_MIN : pos_x - pos_t'(`WALK_STEP);
        end

        // Take-off tick only sets the speed, motion starts next tick
        if (on_ground) begin
            if (jump_now) begin
                vel_next = vel_t'(`JUMP_VEL);
                ground_next = 1'b0;
            end
        end else if (y_try >= Y_REST) begin
            y_next = Y_REST;
            vel_next = '0;
            ground_next = 1'b1;
        end else begin
            y_next = y_try;
            vel_next = vel - vel_t'(`GRAVITY);
        end

        if (!ground_next) begin
            state_next = (vel_next > 0) ? motion_rise : motion_fall;
        end else if (left ^ right) begin
            state_next = motion_walk;
        end else begin
            state_next = motion_idle;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            pos_x <= pos_t'(`START_X);
            pos_y <= Y_REST;
            vel <= '0;
            on_ground <= 1'b1;
            state <= motion_idle;
        end else if (game_tick) begin
            pos_x <= x_next;
            pos_y <= y_next;
            vel <= vel_next;
            on_ground <= ground_next;
            state <= state_next;
        end
    end

    assign chr.pos_x = pos_x;
    assign chr.pos_y = pos_y;
    assign chr.on_ground = on_ground;
    assign chr.state = state;

    a_x_in_walls: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        pos_x >= X_MIN && pos_x <= X_MAX);
    a_y_above_floor: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        pos_y <= Y_REST);
    a_ground_still: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        on_ground |-> vel == '0);
endmodule

/* vga_timing.sv */
`timescale 1ns/1ns
`include "game_consts.svh"

module vga_timing (
    input logic sys_clk,
    input logic sys_rst_n,
    vga_if.src  vga
);
    import video_pkg::*;

    localparam int DIV_W = $clog2(`PIX_DIV);
    localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT;
    localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT;

    logic [DIV_W-1:0] div_cnt;
    coord_t h_next;
    coord_t v_next;

    // One tick every PIX_DIV clocks
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            div_cnt <= '0;
            vga.pix_tick <= 1'b0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            vga.pix_tick <= (div_cnt == DIV_W'(`PIX_DIV - 1));
        end
    end

    // Next scan position, y steps when x wraps
    always_comb begin
        h_next = (vga.x == coord_t'(H_TOTAL - 1)) ? '0 : vga.x + 1'b1;
        v_next = vga.y;
        if (vga.x == coord_t'(H_TOTAL - 1)) begin
            v_next = (vga.y == coord_t'(V_TOTAL - 1)) ? '0 : vga.y + 1'b1;
        end
    end

    // Decodes are taken from the next position so they line up with x and y
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            vga.x <= '0;
            vga.y <= '0;
            vga.hsync <= 1'b1;
            vga.vsync <= 1'b1;
            vga.video_on <= 1'b1;
        end else if (vga.pix_tick) begin
            vga.x <= h_next;
            vga.y <= v_next;
            vga.hsync <= !(h_next >= coord_t'(H_SYNC_START) &&
                           h_next < coord_t'(H_SYNC_START + `H_SYNC));
            vga.vsync <= !(v_next >= coord_t'(V_SYNC_START) &&
                           v_next < coord_t'(V_SYNC_START + `V_SYNC));
            vga.video_on <= (h_next < coord_t'(`H_ACTIVE)) && (v_next < coord_t'(`V_ACTIVE));
        end
    end

    // Downstream logic relies on single-clock ticks
    a_tick_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        vga.pix_tick |=> !vga.pix_tick);
endmodule

/* btn_debounce.sv */
`timescale 1ns/1ns
`include "game_consts.svh"

module btn_debounce (
    input  logic sys_clk,
    input  logic sys_rst_n,
    input  logic raw,
    output logic level,
    output logic rise
);
    localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES);

    logic [1:0] sync_q;
    logic [CNT_W-1:0] stable_cnt;
    logic level_d;

    // Two-flop synchroniser for the asynchronous button
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[0], raw};
        end
    end

    // Count samples that disagree with the current level
    // Any agreeing sample restarts the count
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            stable_cnt <= '0;
            level <= 1'b0;
        end else if (sync_q[1] == level) begin
            stable_cnt <= '0;
        end else if (stable_cnt == CNT_W'(`DEBOUNCE_CYCLES - 1)) begin
            stable_cnt <= '0;
            level <= sync_q[1];
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    // Rise pulse lands one clock after the level goes high
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            level_d <= 1'b0;
            rise <= 1'b0;
        end else begin
            level_d <= level;
            rise <= level && !level_d;
        end
    end
endmodule

/* game_ifs.sv */
`timescale 1ns/1ns

// Scan position and sync from the timing generator
interface vga_if;
    import video_pkg::*;

    coord_t x;
    coord_t y;
    logic video_on;
    logic pix_tick;
    logic hsync;
    logic vsync;

    modport src (output x, y, video_on, pix_tick, hsync, vsync);
    modport snk (input x, y, video_on, pix_tick);
endinterface

// Character position and status from the physics block
interface char_if;
    import game_pkg::*;

    pos_t pos_x;
    pos_t pos_y;
    logic on_ground;
    motion_t state;

    modport src (output pos_x, pos_y, on_ground, state);
    modport snk (input pos_x, pos_y);
endinterface

/* game_pkg.sv */
package game_pkg;

    // Screen position of the character's top-left corner
    // Signed so that intermediate sums below zero compare correctly
    typedef logic signed [10:0] pos_t;

    // Vertical speed, positive is upwards
    typedef logic signed [5:0] vel_t;

    // What the character is doing after the latest game tick
    typedef enum logic [1:0] {
        motion_idle,
        motion_walk,
        motion_rise,
        motion_fall
    } motion_t;

endpackage

/* video_pkg.sv */
package video_pkg;

    // One pixel colour, 4 bits per channel
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // Scan position, wide enough for 800 columns and 525 lines
    typedef logic [9:0] coord_t;

endpackage

/* game_consts.svh */
`ifndef GAME_CONSTS_SVH
`define GAME_CONSTS_SVH

// VGA 640x480, horizontal in pixels
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48

// Vertical in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

// System clocks per pixel
`define PIX_DIV 4

// Stable clocks before a button level is accepted
`define DEBOUNCE_CYCLES 16

// System clocks per physics step
`define GAME_TICK_CYCLES 1000

// Scene geometry in pixels
`define CHAR_SIZE 16
`define WALL_W 8
`define GROUND_Y 440
`define START_X 312

// Motion, pixels per game tick
`define WALK_STEP 2
`define JUMP_VEL 8
`define GRAVITY 1

// 12-bit colours as r, g, b nibbles
`define COL_CHAR 12'hF80
`define COL_FLOOR 12'h4A2
`define COL_WALL 12'h888
`define COL_BG 12'h125

`endif
